// File: core_id.sv
`timescale 1ns/1ps
`default_nettype none

module core_id #(
   parameter logic [63:0] CORE_ID_TEXT = {"ZXIO01", 16'h0000}   // First char in top byte
) (
   input  logic                         clk,
   input  logic                         rst_n,
   output logic [zxuno_pkg::DATA_W-1:0] dout,
   output logic                         oe_n,
   zxuno_reg_if.device                  bus
);

   // Slot of the first zero byte or the last slot for a full text
   function automatic logic [2:0] term_pos(input logic [63:0] text);
      logic [2:0] pos;
      pos = 3'd7;
      for (int i = 7; i >= 0; i--) begin
         if (text[(7 - i) * 8 +: 8] == 8'h00) begin
            pos = 3'(i);   // Lowest index wins
         end
      end
      return pos;
   endfunction

   localparam zxuno_pkg::zxuno_reg_e MY_REG = zxuno_pkg::REG_COREID;
   localparam logic [2:0] TERM_POS = term_pos(CORE_ID_TEXT);

   logic [2:0]                   ptr;        // Next character to return
   logic [zxuno_pkg::DATA_W-1:0] cur_char;
   logic                         reg_hit;    // Id register selected

   assign reg_hit  = (bus.zxuno_addr == MY_REG);
   assign cur_char = CORE_ID_TEXT[(7 - int'(ptr)) * 8 +: 8];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= 3'd0;
      end else if (bus.regaddr_changed) begin
         ptr <= 3'd0;   // Restart the string
      end else if (bus.regrd_done && reg_hit) begin
         if (ptr == TERM_POS) begin
            ptr <= 3'd0;   // Terminator was just read
         end else begin
            ptr <= ptr + 3'd1;
         end
      end
   end

   //////////////////////////////
   // CPU readback
   //////////////////////////////
   assign dout = cur_char;
   assign oe_n = ~(bus.regrd & reg_hit);

   // Reading the zero byte sends the pointer home so it never runs past the text end
   assert property (@(posedge clk) disable iff (!rst_n)
      (bus.regrd_done && reg_hit && cur_char == 8'h00) |=> (ptr == 3'd0))
      else $error("core_id: pointer past terminator");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f zxuno_io.f --top-module tb_zxuno_io -o sim_zxuno_io \
   && ./obj_dir/sim_zxuno_io > sim.log 2>&1 \
   || { echo "Build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: PASS" sim.log \
   && echo "Result: pass" \
   || { echo "Result: fail"; exit 1; }

// File: scratch_register.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_register (
   input  logic                         clk,
   input  logic                         rst_n,
   output logic [zxuno_pkg::DATA_W-1:0] dout,
   output logic                         oe_n,
   zxuno_reg_if.device                  bus
);

   localparam zxuno_pkg::zxuno_reg_e MY_REG = zxuno_pkg::REG_SCRATCH;

   logic [zxuno_pkg::DATA_W-1:0] scratch;   // Stored byte
   logic                         reg_hit;

   assign reg_hit = (bus.zxuno_addr == MY_REG);

   // Byte only changes on a data write to this register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scratch <= '0;
      end else if (bus.regwr && reg_hit) begin
         scratch <= bus.wdata;
      end
   end

   assign dout = scratch;
   assign oe_n = ~(bus.regrd & reg_hit);   // Drive only on our read

endmodule

`default_nettype wire

// File: tb_zxuno_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zxuno_io;

   localparam int          CLK_PERIOD = 100;
   localparam logic [63:0] ID_TEXT    = {"T01-24", 16'h0000};   // Six chars and zero padding
   // Bus operations per test from reset to events
   localparam int          NUM_OPS    = 1 + 17 + 17 + 14 + 8;

   logic                                clk;
   logic                                rst_n;
   logic [15:0]                         a;
   logic [7:0]                          din;
   logic                                iorq_n;
   logic                                rd_n;
   logic                                wr_n;
   logic [zxuno_pkg::EVENT_BITS-1:0]    user_toggles;
   logic [7:0]                          cpu_dout;
   logic                                cpu_oe_n;
   logic                                nmi_n;

   // Reference model state
   logic [7:0]                          m_addr;
   logic [7:0]                          m_scratch;
   int                                  m_ptr;
   logic [zxuno_pkg::EVENT_BITS-1:0]    m_events;
   logic [zxuno_pkg::EVENT_BITS-1:0]    toggles_prev;

   string       name_q[$];   // Pending results for the compare process
   logic [8:0]  exp_q[$];
   logic [8:0]  act_q[$];
   int          errors;
   int          checks;
   logic [7:0]  data;

   zxuno_io #(.CORE_ID_TEXT(ID_TEXT)) u_dut (
      .clk(clk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .user_toggles(user_toggles), .cpu_dout(cpu_dout), .cpu_oe_n(cpu_oe_n), .nmi_n(nmi_n)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////
   // Reference model
   //////////////////////////////
   // {oe_n, data} expected on the CPU bus for a read of port
   function automatic logic [8:0] expected_read(input logic [15:0] port);
      if (port == zxuno_pkg::ADDR_PORT) return {1'b0, m_addr};
      if (port != zxuno_pkg::DATA_PORT) return 9'h1FF;   // Nobody drives
      case (m_addr)
         8'hFF:   return {1'b0, ID_TEXT[(7 - m_ptr) * 8 +: 8]};
         8'hFE:   return {1'b0, m_scratch};
         8'h08:   return {4'b0000, m_events};   // Zeros above the event bits
         default: return 9'h1FF;
      endcase
   endfunction

   task automatic model_after_read(input logic [15:0] port);
      if (port == zxuno_pkg::DATA_PORT && m_addr == 8'hFF) begin
         if (ID_TEXT[(7 - m_ptr) * 8 +: 8] == 8'h00 || m_ptr == 7) m_ptr = 0;
         else m_ptr = m_ptr + 1;
      end else if (port == zxuno_pkg::DATA_PORT && m_addr == 8'h08) begin
         m_events = '0;   // Toggles stay still during reads
      end
   endtask

   //////////////////////////////
   // Checking
   //////////////////////////////
   task automatic check_value(input string name, input logic [8:0] exp, input logic [8:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic post_result(input string name, input logic [8:0] exp, input logic [8:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   // Compare process drains results once per cycle
   always @(negedge clk) begin
      while (act_q.size() > 0) begin
         check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
   end

   task automatic check_nmi(input string name);
      @(negedge clk);
      post_result(name, {8'h00, (m_events == '0)}, {8'h00, nmi_n});
   endtask

   //////////////////////////////
   // Bus tasks
   //////////////////////////////
   task automatic io_write(input logic [15:0] port, input logic [7:0] value);
      @(posedge clk);
      #1 a = port;
      din    = value;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      repeat (3) @(posedge clk);   // Long strobe counted once
      #1 iorq_n = 1'b1;
      wr_n = 1'b1;
      if (port == zxuno_pkg::ADDR_PORT) begin
         m_addr = value;
         m_ptr  = 0;   // Address write restarts the id text
      end else if (port == zxuno_pkg::DATA_PORT && m_addr == 8'hFE) begin
         m_scratch = value;
      end
   endtask

   task automatic io_read(input logic [15:0] port, input string name);
      logic [8:0] exp;
      exp = expected_read(port);
      @(posedge clk);
      #1 a = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(negedge clk);   // Combinational data settled
      post_result(name, exp, {cpu_oe_n, cpu_dout});
      repeat (3) @(posedge clk);
      #1 iorq_n = 1'b1;
      rd_n = 1'b1;
      model_after_read(port);
      repeat (3) @(posedge clk);   // Room for regrd_done side effects
   endtask

   task automatic set_toggles(input logic [zxuno_pkg::EVENT_BITS-1:0] value);
      @(posedge clk);
      #1 user_toggles = value;
      m_events     = m_events | (value & ~toggles_prev);   // Rising edges only
      toggles_prev = value;
      repeat (3) @(posedge clk);
   endtask

   initial begin
      #(CLK_PERIOD * (NUM_OPS * 8 + 100));
      $display("Watchdog timeout, bus operations did not complete in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial begin
      void'($urandom(32'h24da45e5));
      clk          = 1'b0;
      rst_n        = 1'b0;
      a            = 16'h0000;
      din          = 8'h00;
      iorq_n       = 1'b1;
      rd_n         = 1'b1;
      wr_n         = 1'b1;
      user_toggles = '0;
      m_addr       = 8'h00;
      m_scratch    = 8'h00;
      m_ptr        = 0;
      m_events     = '0;
      toggles_prev = '0;
      errors       = 0;
      checks       = 0;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      // Reset state
      @(negedge clk);
      post_result("reset oe_n", 9'h001, {8'h00, cpu_oe_n});
      check_nmi("reset nmi_n");
      io_read(zxuno_pkg::ADDR_PORT, "reset addr");
      // Address register and unmapped port
      repeat (8) begin
         data = 8'($urandom);
         io_write(zxuno_pkg::ADDR_PORT, data);
         io_read(zxuno_pkg::ADDR_PORT, "addr readback");
      end
      io_read(16'h00FE, "unmapped port");
      // Scratch byte
      io_write(zxuno_pkg::ADDR_PORT, zxuno_pkg::REG_SCRATCH);
      repeat (6) begin
         io_write(zxuno_pkg::DATA_PORT, 8'($urandom));
         io_read(zxuno_pkg::DATA_PORT, "scratch readback");
      end
      io_write(zxuno_pkg::ADDR_PORT, 8'h40);   // Unused register
      io_write(zxuno_pkg::DATA_PORT, 8'($urandom));
      io_write(zxuno_pkg::ADDR_PORT, zxuno_pkg::REG_SCRATCH);
      io_read(zxuno_pkg::DATA_PORT, "scratch kept");
      // Core id text with wrap and restart
      io_write(zxuno_pkg::ADDR_PORT, zxuno_pkg::REG_COREID);
      repeat (10) io_read(zxuno_pkg::DATA_PORT, "core id");
      io_write(zxuno_pkg::ADDR_PORT, zxuno_pkg::REG_COREID);
      repeat (2) io_read(zxuno_pkg::DATA_PORT, "core id restart");
      // User events
      io_write(zxuno_pkg::ADDR_PORT, zxuno_pkg::REG_EVENTS);
      set_toggles(5'b00101);
      check_nmi("nmi on event");
      io_read(zxuno_pkg::DATA_PORT, "events read");
      check_nmi("nmi cleared");
      set_toggles(5'b00101);   // Held high so no new edge
      io_read(zxuno_pkg::DATA_PORT, "events held");
      set_toggles(5'b00100);
      set_toggles(5'b10101);
      check_nmi("nmi on new events");
      io_read(zxuno_pkg::DATA_PORT, "events again");
      check_nmi("nmi final");
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: user_events.sv
`timescale 1ns/1ps
`default_nettype none

module user_events (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [zxuno_pkg::EVENT_BITS-1:0] user_toggles,
   output logic [zxuno_pkg::DATA_W-1:0]     dout,
   output logic                             oe_n,
   output logic                             nmi_n,
   zxuno_reg_if.device                      bus
);

   localparam zxuno_pkg::zxuno_reg_e MY_REG = zxuno_pkg::REG_EVENTS;

   logic [zxuno_pkg::EVENT_BITS-1:0] toggles_q;   // Toggles one clock ago
   logic [zxuno_pkg::EVENT_BITS-1:0] rise;        // New rising edges
   logic [zxuno_pkg::EVENT_BITS-1:0] events;      // Sticky event bits
   logic [zxuno_pkg::EVENT_BITS-1:0] shown;       // Bits seen by the last read
   logic                             reg_hit;     // Events register selected
   logic                             clear;

   assign reg_hit = (bus.zxuno_addr == MY_REG);
   assign rise    = user_toggles & ~toggles_q;
   assign clear   = bus.regrd_done & reg_hit;   // Read of this register just ended

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         toggles_q <= '0;
         events    <= '0;
         shown     <= '0;
         nmi_n     <= 1'b1;
      end else begin
         toggles_q <= user_toggles;
         nmi_n     <= ~|events;   // One clock behind the bits
         if (bus.regrd && reg_hit) begin
            shown <= events;
         end
         if (clear) begin
            events <= (events & ~shown) | rise;   // New edges survive the clear
         end else begin
            events <= events | rise;
         end
      end
   end

   //////////////////////////////
   // CPU readback
   //////////////////////////////
   assign dout = {{(zxuno_pkg::DATA_W - zxuno_pkg::EVENT_BITS){1'b0}}, events};
   assign oe_n = ~(bus.regrd & reg_hit);

   // A pending bit stays and holds NMI low until a read clears it
   assert property (@(posedge clk) disable iff (!rst_n)
      (|events && !clear) |=> (!nmi_n && |events))
      else $error("user_events: pending event lost or NMI not asserted");

endmodule

`default_nettype wire

// File: zxuno_io.f
zxuno_pkg.sv
zxuno_reg_if.sv
zxuno_regs.sv
core_id.sv
scratch_register.sv
user_events.sv
zxuno_io.sv
tb_zxuno_io.sv

// File: zxuno_io.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_io #(
   parameter logic [63:0] CORE_ID_TEXT = {"ZXIO01", 16'h0000}
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [zxuno_pkg::IO_ADDR_W-1:0]  a,
   input  logic [zxuno_pkg::DATA_W-1:0]     din,
   input  logic                             iorq_n,
   input  logic                             rd_n,
   input  logic                             wr_n,
   input  logic [zxuno_pkg::EVENT_BITS-1:0] user_toggles,
   output logic [zxuno_pkg::DATA_W-1:0]     cpu_dout,
   output logic                             cpu_oe_n,
   output logic                             nmi_n
);

   logic [zxuno_pkg::DATA_W-1:0] regs_dout;      // Register number readback
   logic [zxuno_pkg::DATA_W-1:0] id_dout;
   logic [zxuno_pkg::DATA_W-1:0] scratch_dout;
   logic [zxuno_pkg::DATA_W-1:0] events_dout;
   logic                         regs_oe_n;
   logic                         id_oe_n;
   logic                         scratch_oe_n;
   logic                         events_oe_n;

   zxuno_reg_if bus ();   // Shared register bank bus

   zxuno_regs u_regs (
      .clk(clk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .dout(regs_dout), .oe_n(regs_oe_n), .bus(bus)
   );

   core_id #(.CORE_ID_TEXT(CORE_ID_TEXT)) u_core_id (
      .clk(clk), .rst_n(rst_n), .dout(id_dout), .oe_n(id_oe_n), .bus(bus)
   );

   scratch_register u_scratch (
      .clk(clk), .rst_n(rst_n), .dout(scratch_dout), .oe_n(scratch_oe_n), .bus(bus)
   );

   user_events u_events (
      .clk(clk), .rst_n(rst_n), .user_toggles(user_toggles), .dout(events_dout),
      .oe_n(events_oe_n), .nmi_n(nmi_n), .bus(bus)
   );

   //////////////////////////////
   // CPU read data by priority
   //////////////////////////////
   always_comb begin
      if (!regs_oe_n) begin
         cpu_dout = regs_dout;      // Address port first
      end else if (!id_oe_n) begin
         cpu_dout = id_dout;
      end else if (!scratch_oe_n) begin
         cpu_dout = scratch_dout;
      end else if (!events_oe_n) begin
         cpu_dout = events_dout;
      end else begin
         cpu_dout = 8'hFF;          // Idle bus
      end
   end

   assign cpu_oe_n = regs_oe_n & id_oe_n & scratch_oe_n & events_oe_n;

endmodule

`default_nettype wire

// File: zxuno_pkg.sv
`default_nettype none

//////////////////////////////
// Register bank constants
//////////////////////////////
package zxuno_pkg;

   localparam int IO_ADDR_W = 16;   // Z80 I/O address width
   localparam int DATA_W    = 8;    // CPU data bus width

   // I/O ports seen by the CPU
   localparam logic [IO_ADDR_W-1:0] ADDR_PORT = 16'hFC3B;  // Register number
   localparam logic [IO_ADDR_W-1:0] DATA_PORT = 16'hFD3B;  // Register contents

   // User toggle inputs latched as events
   localparam int EVENT_BITS = 5;

   // Extended register numbers
   typedef enum logic [DATA_W-1:0] {
      REG_EVENTS  = 8'h08,   // Sticky user events
      REG_SCRATCH = 8'hFE,   // General purpose byte
      REG_COREID  = 8'hFF    // Core id text stream
   } zxuno_reg_e;

endpackage

`default_nettype wire

// File: zxuno_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Register bank bus from the port decoder to the devices
interface zxuno_reg_if;

   logic [zxuno_pkg::DATA_W-1:0] zxuno_addr;   // Selected register
   logic [zxuno_pkg::DATA_W-1:0] wdata;        // Byte of the last data write
   logic                         regwr;        // Write pulse, one cycle
   logic                         regrd;        // Data read in progress
   logic                         regrd_done;   // Pulse after a data read ends
   logic                         regaddr_changed;

   // Port decoder side
   modport master (
      output zxuno_addr,
      output wdata,
      output regwr,
      output regrd,
      output regrd_done,
      output regaddr_changed
   );

   // Register devices only listen
   modport device (
      input zxuno_addr,
      input wdata,
      input regwr,
      input regrd,
      input regrd_done,
      input regaddr_changed
   );

endinterface

`default_nettype wire

// File: zxuno_regs.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [zxuno_pkg::IO_ADDR_W-1:0] a,
   input  logic [zxuno_pkg::DATA_W-1:0]    din,
   input  logic                            iorq_n,
   input  logic                            rd_n,
   input  logic                            wr_n,
   output logic [zxuno_pkg::DATA_W-1:0]    dout,    // Address register readback
   output logic                            oe_n,
   zxuno_reg_if.master                     bus
);

   logic                         addr_sel;      // ADDR_PORT decoded
   logic                         data_sel;      // DATA_PORT decoded
   logic                         io_wr;         // Raw write strobe
   logic                         io_rd;         // Raw read strobe
   logic                         wr_prev;
   logic                         wr_edge;       // First cycle of a write
   logic                         data_rd;
   logic                         data_rd_prev;
   logic [zxuno_pkg::DATA_W-1:0] reg_addr;      // Current register number
   logic                         regwr_q;
   logic                         regaddr_changed_q;
   logic                         regrd_done_q;

   //////////////////////////////
   // Port decode
   //////////////////////////////
   assign addr_sel = (a == zxuno_pkg::ADDR_PORT);
   assign data_sel = (a == zxuno_pkg::DATA_PORT);
   assign io_wr    = ~iorq_n & ~wr_n;
   assign io_rd    = ~iorq_n & ~rd_n;
   assign wr_edge  = io_wr & ~wr_prev;   // Long strobes count once
   assign data_rd  = io_rd & data_sel;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_prev           <= 1'b0;
         data_rd_prev      <= 1'b0;
         reg_addr          <= '0;
         regwr_q           <= 1'b0;
         regaddr_changed_q <= 1'b0;
         regrd_done_q      <= 1'b0;
      end else begin
         wr_prev           <= io_wr;
         data_rd_prev      <= data_rd;
         regwr_q           <= wr_edge & data_sel;
         regaddr_changed_q <= wr_edge & addr_sel;   // Every address write even with the same value
         regrd_done_q      <= data_rd_prev & ~data_rd;  // Falling edge of the read
         if (wr_edge && addr_sel) begin
            reg_addr <= din;
         end
      end
   end

   // Data byte for the devices is qualified by regwr
   always_ff @(posedge clk) begin
      if (wr_edge && data_sel) begin
         bus.wdata <= din;
      end
   end

   //////////////////////////////
   // Register bank side
   //////////////////////////////
   assign bus.zxuno_addr      = reg_addr;
   assign bus.regwr           = regwr_q;
   assign bus.regrd           = data_rd;   // Level, follows the strobe
   assign bus.regrd_done      = regrd_done_q;
   assign bus.regaddr_changed = regaddr_changed_q;

   // CPU reads back the register number
   assign dout = reg_addr;
   assign oe_n = ~(io_rd & addr_sel);

   // Devices never see a write and a read in the same cycle
   assert property (@(posedge clk) disable iff (!rst_n) !(bus.regwr && bus.regrd))
      else $error("zxuno_regs: regwr and regrd high together");

endmodule

`default_nettype wire
